// ==== src.f ====
+incdir+include
src/hack_isa_pkg.sv
src/hack_bus_pkg.sv
src/hack_alu.sv
src/hack_cpu.sv
src/hack_rom.sv
src/hack_ram.sv
src/hack_computer.sv
test/hack_checker.sv
test/tb_hack_computer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f src.f --top-module tb_hack_computer \
  -o tb_hack_computer > build.log 2>&1 \
  && ./obj_dir/tb_hack_computer > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation step failed"; exit 1; }
cat sim.log
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/hack_cases.txt ====
// Per case, all hex: program length, cycle budget, expected output count,
// then the program words, then the expected out_word values. Length 0 ends the list.

// Constants moved through D to the output address.
000E 0080 0003
1234 EC10 6000 E308 0042 EC10 6000 E308
7FFF EC10 6000 E308 000C EA87
1234 0042 7FFF

// All eighteen comp codes with D = 2345 and A = 6000, each written as M.
0017 0100 0012
2345 EC10 6000
EA88 EFC8 EE88 E308 EC08 E348 EC48 E3C8 ECC8
E7C8 EDC8 E388 EC88 E088 E4C8 E1C8 E008 E548
0015 EA87
0000 0001 FFFF 2345 6000 DCBA 9FFF DCBB A000
2346 6001 2344 5FFF 8345 C345 3CBB 2000 6345

// Stores to RAM, M operand sums, output register read-back, unmapped read.
0017 0100 0004
0100 EC10 0010 E308 0234 EC10 0011 E308
0010 FC10 0011 F090 6000 E308 F090 E308
FDC8 0500 FC10 6000 E7C8 0015 EA87
0334 0668 0669 0001

// Count-down loop, JGT JEQ JLT each taken and not taken. 0BAD marks a wrong path.
0021 0100 0005
0003 EC10 001B E304 6000 E308 0004 E391
000C E302 001B EA87 E390 6000 E308 001B
E302 0015 E304 001B EA87 0077 EC10 6000
E308 0019 EA87 0BAD EC10 6000 E308 001F
EA87
0003 0002 0001 FFFF 0077

// Runs after a mid-run reset; first output is D+A+1 and only 1 when both were cleared.
000A 0080 0002
E090 E7D0 6000 E308 0055 E090 6000 E308
0008 EA87
0001 0056

0000 0000 0000

// ==== test/tb_hack_computer.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_hack_computer;

  localparam int case_words = 512;
  localparam int reset_cycles = 5;
  localparam int drain_cycles = 16;

  logic        clk;
  logic        reset;
  logic        prog_we;
  logic [15:0] prog_addr;
  logic [15:0] prog_data;
  wire logic        out_valid;
  wire logic [15:0] out_word;
  wire logic [15:0] pc;

  logic [15:0] case_mem [case_words];
  int          cycles = 0;
  int          cycle_limit = 0;
  int          tb_errors = 0;

  hack_computer hack_computer_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .out_valid (out_valid),
    .out_word  (out_word),
    .pc        (pc)
  );

  hack_checker hack_checker_i (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .out_word  (out_word),
    .pc        (pc)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Budgets plus reset, load and drain time of every case.
  function automatic int overall_limit();
    int p;
    int total;
    p = 0;
    total = 0;
    while (p + 2 < case_words && case_mem[p] != 16'h0000) begin
      total += int'(case_mem[p+1]) + int'(case_mem[p]) + reset_cycles + drain_cycles + 4;
      p += 3 + int'(case_mem[p]) + int'(case_mem[p+2]);
    end
    return total + 8;
  endfunction

  // Holds reset and writes the program through the program port.
  task automatic load_program(input int start, input int count);
    int i;
    @(posedge clk);
    reset <= 1'b1;
    repeat (reset_cycles) @(posedge clk);
    for (i = 0; i < count; i++) begin
      prog_we   <= 1'b1;
      prog_addr <= 16'(i);
      prog_data <= case_mem[start+i];
      @(posedge clk);
    end
    prog_we <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run stopped: overall limit of %0d cycles reached at pc %04h", cycle_limit, pc);
      $display("Errors: %0d mismatches, %0d other", hack_checker_i.mismatches,
               hack_checker_i.other_errors + tb_errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int pos;
    int n_prog;
    int budget;
    int n_exp;
    int case_no;
    int waited;
    int i;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = 16'h0000;
    prog_data = 16'h0000;
    $readmemh("test/hack_cases.txt", case_mem);
    cycle_limit = overall_limit();
    pos = 0;
    case_no = 0;
    while (pos + 2 < case_words && case_mem[pos] != 16'h0000) begin
      n_prog = int'(case_mem[pos]);
      budget = int'(case_mem[pos+1]);
      n_exp  = int'(case_mem[pos+2]);
      pos += 3;
      case_no++;
      load_program(pos, n_prog);
      pos += n_prog;
      for (i = 0; i < n_exp; i++) begin
        hack_checker_i.push_expected(case_mem[pos+i]);
      end
      pos += n_exp;
      @(posedge clk);
      reset <= 1'b0;
      waited = 0;
      while (hack_checker_i.pending() > 0 && waited < budget) begin
        @(negedge clk);
        waited++;
      end
      if (hack_checker_i.pending() > 0) begin
        $display("Timeout in case %0d: %0d outputs still missing after %0d cycles, pc at %04h",
                 case_no, hack_checker_i.pending(), budget, pc);
        tb_errors++;
        hack_checker_i.clear_expected();
      end
      repeat (drain_cycles) @(posedge clk); // Catches stray outputs.
    end
    if (case_no == 0) begin
      $display("No cases were read from test/hack_cases.txt");
      tb_errors++;
    end
    $display("Errors: %0d mismatches, %0d other", hack_checker_i.mismatches,
             hack_checker_i.other_errors + tb_errors);
    if (hack_checker_i.mismatches == 0 && hack_checker_i.other_errors + tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/hack_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

module hack_checker (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        out_valid,
  input wire logic [15:0] out_word,
  input wire logic [15:0] pc
);

  logic [15:0] expected_q [$];
  logic        reset_q = 1'b0;
  int          mismatches = 0;
  int          other_errors = 0;

  task automatic push_expected(input logic [15:0] value);
    expected_q.push_back(value);
  endtask

  // Drops what is left after a case ran out of cycles.
  task automatic clear_expected();
    expected_q.delete();
  endtask

  function automatic int pending();
    return expected_q.size();
  endfunction

  always @(posedge clk) begin
    logic [15:0] head;
    reset_q <= reset;
    // A reset held through a full cycle leaves pc at 0.
    if (reset && reset_q && pc !== 16'h0000) begin
      $display("mismatch pc expected %04h actual %04h", 16'h0000, pc);
      mismatches++;
    end
    if (!reset && out_valid) begin
      if (expected_q.size() == 0) begin
        $display("Output word %04h arrived when no value was expected", out_word);
        other_errors++;
      end else begin
        head = expected_q.pop_front();
        if (out_word !== head) begin
          $display("mismatch out_word expected %04h actual %04h", head, out_word);
          mismatches++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/hack_computer.sv ====
`default_nettype none
`timescale 1ns/1ns

module hack_computer (
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         prog_we,
  input  wire logic [15:0]  prog_addr,
  input  wire logic [15:0]  prog_data,
  output wire logic         out_valid,
  output wire logic [15:0]  out_word,
  output wire logic [15:0]  pc
);

  import hack_isa_pkg::*;
  import hack_bus_pkg::*;

  instr_t  instr;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  hack_rom hack_rom_i (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  hack_cpu hack_cpu_i (
    .clk    (clk),
    .reset  (reset),
    .instr  (instr),
    .pc     (pc),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  hack_ram hack_ram_i (
    .clk       (clk),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

endmodule

`default_nettype wire

// ==== src/hack_ram.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "hack_params.svh"

module hack_ram (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire hack_bus_pkg::wb_req_t  wb_req,
  output hack_bus_pkg::wb_rsp_t       wb_rsp,
  output logic                        out_valid,
  output logic [15:0]                 out_word
);

  localparam int addr_bits = $clog2(`HACK_RAM_DEPTH);

  logic [15:0] mem [`HACK_RAM_DEPTH];
  logic [15:0] rd_q;
  logic        ack_q;
  logic        access;
  logic        sel_ram;
  logic        sel_out;

  // First cycle of a transfer, ack follows one cycle later.
  assign access  = wb_req.cyc && wb_req.stb && !ack_q;
  assign sel_ram = wb_req.adr < 16'(`HACK_RAM_DEPTH);
  assign sel_out = wb_req.adr == `HACK_OUT_ADDR;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      ack_q     <= access;
      out_valid <= access && wb_req.we && sel_out; // Lines up with ack.
    end
  end

  always_ff @(posedge clk) begin
    if (access && wb_req.we && sel_ram) begin
      mem[wb_req.adr[addr_bits-1:0]] <= wb_req.dat;
    end
    if (access && wb_req.we && sel_out) begin
      out_word <= wb_req.dat;
    end

    if (access) begin
      if (sel_ram) begin
        rd_q <= mem[wb_req.adr[addr_bits-1:0]];
      end else if (sel_out) begin
        rd_q <= out_word;
      end else begin
        rd_q <= 16'h0000; // Unmapped.
      end
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rd_q};

  a_ack_with_stb: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |-> wb_req.stb);

endmodule

`default_nettype wire

// ==== src/hack_rom.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "hack_params.svh"

module hack_rom (
  input  wire logic [15:0]  prog_addr,
  input  wire logic [15:0]  prog_data,
  input  wire logic [15:0]  pc,
  input  wire logic         clk,
  input  wire logic         prog_we,
  output hack_isa_pkg::instr_t instr
);

  localparam int addr_bits = $clog2(`HACK_ROM_DEPTH);

  logic [15:0] rom [`HACK_ROM_DEPTH];

  always_ff @(posedge clk) begin
    if (prog_we && (prog_addr < 16'(`HACK_ROM_DEPTH))) begin
      rom[prog_addr[addr_bits-1:0]] <= prog_data;
    end

    if (pc < 16'(`HACK_ROM_DEPTH)) begin
      instr.word <= rom[pc[addr_bits-1:0]];
    end else begin
      instr.word <= 16'h0000; // Decodes as @0.
    end
  end

endmodule

`default_nettype wire

// ==== src/hack_cpu.sv ====
`default_nettype none
`timescale 1ns/1ns

module hack_cpu (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire hack_isa_pkg::instr_t   instr,
  output logic [15:0]                 pc,
  output hack_bus_pkg::wb_req_t       wb_req,
  input  wire hack_bus_pkg::wb_rsp_t  wb_rsp
);

  import hack_isa_pkg::*;

  cpu_state_t  state;
  c_fields_t   ctl_q;
  logic [15:0] a_reg;
  logic [15:0] d_reg;
  logic [15:0] y_q;

  logic [15:0] alu_out;
  logic        alu_zero;
  logic        alu_neg;
  logic        alu_pos;
  logic        jump;

  assign alu_pos = !(alu_neg || alu_zero);
  assign jump = (ctl_q.jlt && alu_neg) || (ctl_q.jeq && alu_zero) || (ctl_q.jgt && alu_pos);

  hack_alu hack_alu_i (
    .x    (d_reg),
    .y    (y_q),
    .ctl  (ctl_q),
    .out  (alu_out),
    .zero (alu_zero),
    .neg  (alu_neg)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_fetch;
      pc         <= '0;
      a_reg      <= '0;
      d_reg      <= '0;
      wb_req.cyc <= 1'b0;
      wb_req.stb <= 1'b0;
      wb_req.we  <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          state <= st_decode; // ROM word is ready next cycle.
        end

        st_decode: begin
          if (instr.word[15]) begin
            ctl_q <= instr.c;
            if (instr.c.a) begin
              // Fetch the M operand first.
              wb_req.cyc <= 1'b1;
              wb_req.stb <= 1'b1;
              wb_req.we  <= 1'b0;
              wb_req.adr <= a_reg;
              state      <= st_mem_read;
            end else begin
              y_q   <= a_reg;
              state <= st_write_back;
            end
          end else begin
            a_reg <= instr.word;
            pc    <= pc + 16'd1;
            state <= st_fetch;
          end
        end

        st_mem_read: begin
          if (wb_rsp.ack) begin
            y_q        <= wb_rsp.dat;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            state      <= st_write_back;
          end
        end

        st_write_back: begin
          if (ctl_q.dest_m && !wb_req.stb) begin
            // Store at the old A before any register changes.
            wb_req.cyc <= 1'b1;
            wb_req.stb <= 1'b1;
            wb_req.we  <= 1'b1;
            wb_req.adr <= a_reg;
            wb_req.dat <= alu_out;
          end else if (!ctl_q.dest_m || wb_rsp.ack) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
            if (ctl_q.dest_a) a_reg <= alu_out;
            if (ctl_q.dest_d) d_reg <= alu_out;
            pc    <= jump ? a_reg : pc + 16'd1; // Target is A before this write.
            state <= st_fetch;
          end
        end

        default: state <= st_fetch;
      endcase
    end
  end

  // Bus requests only come from the two bus states.
  a_stb_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb |-> wb_req.cyc && (state == st_mem_read || state == st_write_back));

  // Request held until the slave acknowledges it.
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr)
      && $stable(wb_req.we) && $stable(wb_req.dat));

endmodule

`default_nettype wire

// ==== src/hack_alu.sv ====
`default_nettype none
`timescale 1ns/1ns

module hack_alu (
  input  wire logic [15:0]              x,
  input  wire logic [15:0]              y,
  input  wire hack_isa_pkg::c_fields_t  ctl,
  output logic [15:0]                   out,
  output logic                          zero,
  output logic                          neg
);

  logic [15:0] x_z, x_n;
  logic [15:0] y_z, y_n;
  logic [15:0] res;

  // Operand conditioning.
  assign x_z = ctl.zx ? 16'h0000 : x;
  assign x_n = ctl.nx ? ~x_z : x_z;
  assign y_z = ctl.zy ? 16'h0000 : y;
  assign y_n = ctl.ny ? ~y_z : y_z;

  assign res = ctl.f ? (x_n + y_n) : (x_n & y_n);
  assign out = ctl.no ? ~res : res;

  // Flags for the jump condition.
  assign zero = (out == 16'h0000);
  assign neg  = out[15];

endmodule

`default_nettype wire

// ==== src/hack_bus_pkg.sv ====
`default_nettype none

package hack_bus_pkg;

  // Wishbone classic signals driven by the master.
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;
    logic [15:0] dat;
  } wb_req_t;

  // Wishbone classic signals driven by the slave.
  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== src/hack_isa_pkg.sv ====
`default_nettype none

package hack_isa_pkg;

  // C-instruction layout, MSB first.
  typedef struct packed {
    logic [2:0] marker;  // 3'b111 on a C-instruction.
    logic       a;       // Y operand from memory instead of A.
    logic       zx;
    logic       nx;
    logic       zy;
    logic       ny;
    logic       f;       // Add when set, AND when clear.
    logic       no;
    logic       dest_a;
    logic       dest_d;
    logic       dest_m;
    logic       jlt;
    logic       jeq;
    logic       jgt;
  } c_fields_t;

  // Bit 15 clear means an A-instruction, and the word is the constant.
  typedef union packed {
    logic [15:0] word;
    c_fields_t   c;
  } instr_t;

  typedef enum logic [1:0] {
    st_fetch      = 2'd0,
    st_decode     = 2'd1,
    st_write_back = 2'd2,
    st_mem_read   = 2'd3
  } cpu_state_t;

endpackage

`default_nettype wire

// ==== include/hack_params.svh ====
`ifndef HACK_PARAMS_SVH
`define HACK_PARAMS_SVH

// Instruction memory size in words.
`define HACK_ROM_DEPTH 1024

// Data memory size in words.
`define HACK_RAM_DEPTH 1024

// Data address of the memory-mapped output register.
`define HACK_OUT_ADDR 16'h6000

`endif
